/* all.f */
rtl/cpu_pkg.sv
rtl/run_control.sv
rtl/program_counter.sv
rtl/instruction_memory.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu_top.sv

/* Makefile */
# Verilator build, run, lint and clean for the cpu_top testbench
TOP := tb_cpu_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f rtl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

/* tb/tb_cpu_top.sv */
`timescale 1ns/1ns

module tb_cpu_top;

    localparam int MAX_CYCLES      = 200;
    localparam int NUM_TESTS       = 10;  // Watchdog budget basis
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_CYCLES + 100);

    logic       clk;
    logic       reset;
    logic       start;
    logic       prog_we;
    logic [5:0] prog_addr;
    logic [8:0] prog_data;
    logic [7:0] host_addr;
    logic       ack;
    logic       timed_out;
    logic [7:0] host_rdata;

    logic [31:0] lfsr = 32'hf26f_12c1;
    logic [8:0]  prog [$];          // Program of the current test
    logic [8:0]  model_imem [64];   // Words the DUT accepted
    logic [7:0]  model_dmem [256];  // Survives runs, like the DUT
    logic [7:0]  touched [$];       // Addresses to read back
    int          cycle_count = 0;
    int          run_start = 0;     // cycle_count at the start edge
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cpu_top #(.MAX_CYCLES(MAX_CYCLES)) u_dut (
        .clk(clk), .reset(reset), .start(start), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .host_addr(host_addr),
        .ack(ack), .timed_out(timed_out), .host_rdata(host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: tests still running after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [5:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[4:0], lfsr[0]};  // One step per bit
        end
    endtask

    function automatic logic [8:0] alu_instr(input logic [2:0] op, input logic [1:0] a, b);
        return {op, a, b, 2'b00};
    endfunction

    function automatic logic [8:0] li_instr(input logic [5:0] v);
        return {cpu_pkg::op_li, v};
    endfunction

    function automatic logic [8:0] beqz_instr(input logic [5:0] offset);
        return {cpu_pkg::op_beqz, offset};
    endfunction

    function automatic logic [8:0] store_instr(input logic [1:0] a, b);
        return {cpu_pkg::op_mem, a, b, 2'b10};  // dmem[ra] = rb
    endfunction

    function automatic logic [8:0] load_instr(input logic [1:0] a, b);
        return {cpu_pkg::op_mem, a, b, 2'b00};  // rb = dmem[ra]
    endfunction

    function automatic logic [8:0] halt_instr();
        return {cpu_pkg::op_halt, 6'd0};
    endfunction

    task automatic expect_value(input string what, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            #1;
            prog_we       = 1'b1;
            prog_addr     = 6'(i);
            prog_data     = prog[i];
            model_imem[i] = prog[i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);              // Start edge
        #1;
        start     = 1'b0;
        run_start = cycle_count;
        expect_value("ack after start", ack, 0);
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        host_addr = addr;
        @(posedge clk);              // Registered readback
        #1;
        data = host_rdata;
    endtask

    // ISA rules on plain arrays, one instruction per step
    task automatic model_run(output int executed, output bit timed);
        logic [7:0] regs [4];
        logic [5:0] pc;
        logic [5:0] pc_next;
        logic [8:0] ins;
        logic [1:0] a;
        logic [1:0] b;
        bit         halted;
        foreach (regs[i]) regs[i] = '0;
        pc       = '0;
        executed = 0;
        halted   = 1'b0;
        touched.delete();
        while (!halted && executed < MAX_CYCLES) begin
            ins     = model_imem[pc];
            a       = ins[5:4];
            b       = ins[3:2];
            pc_next = pc + 6'd1;
            executed++;
            case (ins[8:6])
                cpu_pkg::op_add:  regs[1] = regs[a] + regs[b];
                cpu_pkg::op_sub:  regs[1] = regs[a] - regs[b];
                cpu_pkg::op_and:  regs[1] = regs[a] & regs[b];
                cpu_pkg::op_xor:  regs[1] = regs[a] ^ regs[b];
                cpu_pkg::op_li:   regs[1] = {2'b00, ins[5:0]};
                cpu_pkg::op_halt: halted = 1'b1;
                cpu_pkg::op_beqz: begin
                    if (regs[1] == 8'd0) begin
                        pc_next = pc + ins[5:0];  // Signed offset, 6-bit wrap
                    end
                end
                default: begin                    // MEM
                    if (ins[1]) begin
                        model_dmem[regs[a]] = regs[b];
                        touched.push_back(regs[a]);
                    end else begin
                        regs[b] = model_dmem[regs[a]];
                    end
                end
            endcase
            pc = pc_next;
        end
        timed = !halted;
    endtask

    task automatic check_touched();
        logic [7:0] got;
        foreach (touched[i]) begin
            read_word(touched[i], got);
            expect_value($sformatf("dmem[%0d]", touched[i]), got, model_dmem[touched[i]]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        int executed;
        bit exp_timeout;
        model_run(executed, exp_timeout);
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        expect_value("cycles from start to ack", cycle_count - run_start, executed + 1);
        expect_value("timed_out", timed_out, exp_timeout);
        check_touched();
        end_test(name);
    endtask

    initial begin
        logic [5:0] x;
        logic [5:0] y;
        int         checker_errors;
        reset     = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        host_addr = '0;
        foreach (model_dmem[i]) model_dmem[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        expect_value("ack after reset", ack, 0);
        expect_value("timed_out after reset", timed_out, 0);
        take_bits(6, x);
        touched = '{8'h00, 8'hff, {2'b00, x}};
        check_touched();
        end_test("reset state");

        take_bits(6, x);
        take_bits(6, y);
        prog = '{li_instr(x), store_instr(0, 1), load_instr(0, 2),  // r2 = x via dmem[0]
                 li_instr(y), store_instr(0, 1), load_instr(0, 3),  // r3 = y
                 alu_instr(cpu_pkg::op_add, 2, 3), store_instr(1, 1),
                 alu_instr(cpu_pkg::op_sub, 2, 3), store_instr(1, 1),
                 alu_instr(cpu_pkg::op_and, 2, 3), store_instr(1, 1),
                 alu_instr(cpu_pkg::op_xor, 2, 3), store_instr(1, 1), halt_instr()};
        load_program();
        start_run();
        finish_test("arithmetic");

        take_bits(6, x);
        take_bits(4, y);
        prog = '{li_instr(x), store_instr(0, 1),                    // dmem[0] = v
                 li_instr(y | 6'h10), load_instr(0, 2), store_instr(1, 2),
                 load_instr(1, 3), li_instr(y | 6'h20), store_instr(1, 3), halt_instr()};
        load_program();
        start_run();
        finish_test("memory");

        take_bits(4, y);
        prog = '{li_instr(1), store_instr(0, 1), load_instr(0, 2),  // r2 = 1
                 store_instr(2, 0), li_instr(y + 6'd1), store_instr(0, 1),
                 load_instr(0, 1), alu_instr(cpu_pkg::op_sub, 1, 2), // Loop at 6
                 store_instr(0, 1), beqz_instr(6'd6),               // Exit to HALT
                 load_instr(2, 1), alu_instr(cpu_pkg::op_add, 1, 2),
                 store_instr(2, 1), li_instr(0), beqz_instr(6'h38), halt_instr()};
        load_program();
        start_run();
        finish_test("branch loop");

        take_bits(5, x);
        prog = '{li_instr(x | 6'h20), store_instr(1, 1), li_instr(0), beqz_instr(0)};
        load_program();
        start_run();
        finish_test("timeout");

        take_bits(6, x);
        take_bits(6, y);
        prog = '{li_instr(x), store_instr(1, 1), li_instr(y), store_instr(1, 1), halt_instr()};
        load_program();
        start_run();
        prog_we   = 1'b1;                // Both must be ignored mid-run
        prog_addr = 6'd2;
        prog_data = li_instr(~y);
        start     = 1'b1;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        start   = 1'b0;
        finish_test("restart");

        checker_errors = u_dut.u_cpu_checker.error_count;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, errors, checker_errors);
        if (tests_failed == 0 && checker_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker (
    input logic clk,
    input logic reset,
    input logic start,
    input logic run,
    input logic ack,
    input logic timed_out
);

    logic started;          // A start was sampled since reset
    int   error_count = 0;  // Failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    no_ack_before_start: assert property (@(posedge clk) disable iff (reset) !started |-> !ack)
        else begin
            error_count++;
            $error("ack went high before any start since reset");
        end

    timeout_needs_ack: assert property (@(posedge clk) disable iff (reset) timed_out |-> ack)
        else begin
            error_count++;
            $error("timed_out is high while ack is low");
        end

    run_ack_exclusive: assert property (@(posedge clk) disable iff (reset) !(run && ack))
        else begin
            error_count++;
            $error("run and ack are high together");
        end

    ack_drops_on_start: assert property (@(posedge clk) disable iff (reset) start |=> !ack)
        else begin
            error_count++;
            $error("ack still high in the cycle after start");
        end

endmodule

bind cpu_top cpu_checker u_cpu_checker (
    .clk(clk), .reset(reset), .start(start), .run(run), .ack(ack), .timed_out(timed_out)
);

/* rtl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 256,
    parameter int MAX_CYCLES = 4096
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   prog_addr,
    input  logic [cpu_pkg::INSTR_WIDTH-1:0] prog_data,
    input  logic [$clog2(DMEM_DEPTH)-1:0]   host_addr,
    output logic                            ack,
    output logic                            timed_out,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  host_rdata
);

    localparam int PC_WIDTH = $clog2(IMEM_DEPTH);

    logic                               run;
    logic                               restart;
    logic                               load_we;    // Host load outside a run
    logic [PC_WIDTH-1:0]                pc;
    logic [cpu_pkg::INSTR_WIDTH-1:0]    instr;
    logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ra;
    logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rb;
    logic [cpu_pkg::IMM_WIDTH-1:0]      imm;
    cpu_pkg::alu_op_e                   alu_op;
    logic                               use_imm;
    logic                               branch_en;
    logic                               reg_write;
    logic                               write_to_rb;
    logic                               mem_read;
    logic                               mem_write;
    logic                               halt;
    logic [cpu_pkg::DATA_WIDTH-1:0]     data_a;
    logic [cpu_pkg::DATA_WIDTH-1:0]     data_b;
    logic [cpu_pkg::DATA_WIDTH-1:0]     data_r1;
    logic                               zero;
    logic [cpu_pkg::DATA_WIDTH-1:0]     write_value;
    logic [cpu_pkg::DATA_WIDTH-1:0]     mem_rdata;

    assign load_we = prog_we && !run;  // Writes during a run are dropped

    run_control #(.MAX_CYCLES(MAX_CYCLES)) u_run_control (
        .clk(clk), .reset(reset), .start(start), .halt(halt),
        .run(run), .restart(restart), .ack(ack), .timed_out(timed_out)
    );

    program_counter #(.IMEM_DEPTH(IMEM_DEPTH)) u_program_counter (
        .clk(clk), .reset(reset), .restart(restart), .run(run),
        .branch_taken_zero(zero), .branch_en(branch_en), .imm(imm), .pc(pc)
    );

    instruction_memory #(.IMEM_DEPTH(IMEM_DEPTH)) u_instruction_memory (
        .clk(clk), .prog_we(load_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .pc(pc), .instr(instr)
    );

    control_decoder u_control_decoder (
        .instr(instr), .run(run), .ra(ra), .rb(rb), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .branch_en(branch_en), .reg_write(reg_write),
        .write_to_rb(write_to_rb), .mem_read(mem_read), .mem_write(mem_write),
        .halt(halt)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .restart(restart), .ra(ra), .rb(rb),
        .reg_write(reg_write), .write_to_rb(write_to_rb), .write_value(write_value),
        .data_a(data_a), .data_b(data_b), .data_r1(data_r1)
    );

    execute_unit u_execute_unit (
        .data_a(data_a), .data_b(data_b), .data_r1(data_r1), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .branch_en(branch_en),
        .mem_read(mem_read), .mem_rdata(mem_rdata), .zero(zero),
        .write_value(write_value)
    );

    data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_data_memory (
        .clk(clk), .reset(reset), .mem_write(mem_write), .data_a(data_a),
        .data_b(data_b), .host_addr(host_addr), .mem_rdata(mem_rdata),
        .host_rdata(host_rdata)
    );

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ns

module data_memory #(
    parameter int DMEM_DEPTH = 256  // Power of two, at most 256
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mem_write,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_a,     // Address from ra
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_b,     // Store data from rb
    input  logic [$clog2(DMEM_DEPTH)-1:0]  host_addr,
    output logic [cpu_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic [cpu_pkg::DATA_WIDTH-1:0] host_rdata
);

    localparam int ADDR_WIDTH = $clog2(DMEM_DEPTH);

    logic [cpu_pkg::DATA_WIDTH-1:0] mem [DMEM_DEPTH];
    logic [ADDR_WIDTH-1:0]          core_addr;

    assign core_addr = data_a[ADDR_WIDTH-1:0];  // Wraps at DMEM_DEPTH
    assign mem_rdata = mem[core_addr];          // Same-cycle load

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;                   // Kept across restart for readback
            end
            host_rdata <= '0;
        end else begin
            if (mem_write) begin
                mem[core_addr] <= data_b;
            end
            host_rdata <= mem[host_addr];       // One cycle readback latency
        end
    end

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_a,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_b,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_r1,
    input  logic [cpu_pkg::IMM_WIDTH-1:0]  imm,
    input  cpu_pkg::alu_op_e               alu_op,
    input  logic                           use_imm,
    input  logic                           branch_en,
    input  logic                           mem_read,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic                           zero,
    output logic [cpu_pkg::DATA_WIDTH-1:0] write_value
);

    localparam int PAD_WIDTH = cpu_pkg::DATA_WIDTH - cpu_pkg::IMM_WIDTH;

    logic [cpu_pkg::DATA_WIDTH-1:0] imm_ext;     // LI immediate, zero-extended
    logic [cpu_pkg::DATA_WIDTH-1:0] operand_b;
    logic [cpu_pkg::DATA_WIDTH-1:0] alu_result;

    assign imm_ext = {{PAD_WIDTH{1'b0}}, imm};

    // Operand b carries r1 for BEQZ, the immediate for LI, rb otherwise
    always_comb begin
        if (branch_en) begin
            operand_b = data_r1;
        end else if (use_imm) begin
            operand_b = imm_ext;
        end else begin
            operand_b = data_b;
        end
    end

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add:    alu_result = data_a + operand_b;
            cpu_pkg::alu_sub:    alu_result = data_a - operand_b;  // Wraps mod 256
            cpu_pkg::alu_and:    alu_result = data_a & operand_b;
            cpu_pkg::alu_xor:    alu_result = data_a ^ operand_b;
            cpu_pkg::alu_pass_b: alu_result = operand_b;
            default:             alu_result = '0;
        endcase
    end

    assign zero = (alu_result == '0);  // Branch condition for the PC

    // Loads write memory data back, everything else the ALU result
    assign write_value = mem_read ? mem_rdata : alu_result;

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               restart,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ra,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rb,
    input  logic                               reg_write,
    input  logic                               write_to_rb,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]     write_value,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     data_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     data_b,
    output logic [cpu_pkg::DATA_WIDTH-1:0]     data_r1
);

    localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_WIDTH;

    logic [cpu_pkg::DATA_WIDTH-1:0]     regs [NUM_REGS];
    logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dest;  // r1 unless a load

    assign dest = write_to_rb ? rb : cpu_pkg::REG_ADDR_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;            // Clean registers every run
            end
        end else if (reg_write) begin
            regs[dest] <= write_value;
        end
    end

    assign data_a  = regs[ra];
    assign data_b  = regs[rb];
    assign data_r1 = regs[1];             // BEQZ condition source

endmodule

/* rtl/control_decoder.sv */
`timescale 1ns/1ns

module control_decoder (
    input  logic [cpu_pkg::INSTR_WIDTH-1:0]    instr,
    input  logic                               run,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ra,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rb,
    output logic [cpu_pkg::IMM_WIDTH-1:0]      imm,
    output cpu_pkg::alu_op_e                   alu_op,
    output logic                               use_imm,
    output logic                               branch_en,
    output logic                               reg_write,
    output logic                               write_to_rb,  // Load targets rb, not r1
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               halt
);

    cpu_pkg::opcode_e opcode;
    logic             is_store;

    assign opcode   = cpu_pkg::opcode_e'(instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
    assign ra       = instr[cpu_pkg::RA_MSB:cpu_pkg::RA_LSB];
    assign rb       = instr[cpu_pkg::RB_MSB:cpu_pkg::RB_LSB];
    assign imm      = instr[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];
    assign is_store = instr[cpu_pkg::LS_BIT];

    always_comb begin
        alu_op      = cpu_pkg::alu_add;  // No-op defaults
        use_imm     = 1'b0;
        branch_en   = 1'b0;
        reg_write   = 1'b0;
        write_to_rb = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        halt        = 1'b0;
        if (run) begin                   // Idle core sees a no-op
            case (opcode)
                cpu_pkg::op_add: begin alu_op = cpu_pkg::alu_add; reg_write = 1'b1; end
                cpu_pkg::op_sub: begin alu_op = cpu_pkg::alu_sub; reg_write = 1'b1; end
                cpu_pkg::op_and: begin alu_op = cpu_pkg::alu_and; reg_write = 1'b1; end
                cpu_pkg::op_xor: begin alu_op = cpu_pkg::alu_xor; reg_write = 1'b1; end
                cpu_pkg::op_li: begin
                    alu_op    = cpu_pkg::alu_pass_b;  // Immediate through b
                    use_imm   = 1'b1;
                    reg_write = 1'b1;
                end
                cpu_pkg::op_beqz: begin
                    alu_op    = cpu_pkg::alu_pass_b;  // r1 through b for zero test
                    branch_en = 1'b1;
                end
                cpu_pkg::op_mem: begin
                    mem_write   = is_store;
                    mem_read    = !is_store;
                    reg_write   = !is_store;
                    write_to_rb = !is_store;
                end
                cpu_pkg::op_halt: halt = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/instruction_memory.sv */
`timescale 1ns/1ns

module instruction_memory #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                            clk,
    input  logic                            prog_we,    // Already gated by !run
    input  logic [$clog2(IMEM_DEPTH)-1:0]   prog_addr,
    input  logic [cpu_pkg::INSTR_WIDTH-1:0] prog_data,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   pc,
    output logic [cpu_pkg::INSTR_WIDTH-1:0] instr
);

    logic [cpu_pkg::INSTR_WIDTH-1:0] mem [IMEM_DEPTH];  // Program store

    // Host load, one word per cycle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch in the same cycle as decode and execute
    assign instr = mem[pc];

endmodule

/* rtl/program_counter.sv */
`timescale 1ns/1ns

module program_counter #(
    parameter int IMEM_DEPTH = 64  // Power of two, PC wraps naturally
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          restart,
    input  logic                          run,
    input  logic                          branch_taken_zero,  // r1 == 0 from execute
    input  logic                          branch_en,
    input  logic [cpu_pkg::IMM_WIDTH-1:0] imm,
    output logic [$clog2(IMEM_DEPTH)-1:0] pc
);

    localparam int PC_WIDTH = $clog2(IMEM_DEPTH);

    logic [PC_WIDTH-1:0] offset;   // Sign-extended branch offset
    logic [PC_WIDTH-1:0] pc_next;

    assign offset = PC_WIDTH'($signed(imm));

    always_comb begin
        if (branch_en && branch_taken_zero) begin
            pc_next = pc + offset;  // Relative to the BEQZ itself
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            pc <= '0;           // Every run starts at address 0
        end else if (run) begin
            pc <= pc_next;
        end
    end

endmodule

/* rtl/run_control.sv */
`timescale 1ns/1ns

module run_control #(
    parameter int MAX_CYCLES = 4096
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic halt,
    output logic run,
    output logic restart,
    output logic ack,
    output logic timed_out
);

    localparam int CNT_WIDTH = $clog2(MAX_CYCLES + 1);

    cpu_pkg::run_state_e  state;
    logic [CNT_WIDTH-1:0] cycle_cnt;   // Executed cycles in this run
    logic                 budget_hit;  // Run ended on budget, not on HALT
    logic                 last_cycle;

    assign run        = (state == cpu_pkg::st_run);
    assign restart    = start && (state != cpu_pkg::st_run);  // Start ignored mid-run
    assign last_cycle = (cycle_cnt == CNT_WIDTH'(MAX_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cpu_pkg::st_idle;
            cycle_cnt  <= '0;
            budget_hit <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::st_idle, cpu_pkg::st_done: begin
                    if (start) begin
                        state      <= cpu_pkg::st_run;
                        cycle_cnt  <= '0;    // Fresh budget per run
                        budget_hit <= 1'b0;
                    end
                end
                cpu_pkg::st_run: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (halt) begin
                        state <= cpu_pkg::st_done;  // HALT wins over the budget
                    end else if (last_cycle) begin
                        state      <= cpu_pkg::st_done;
                        budget_hit <= 1'b1;
                    end
                end
                default: state <= cpu_pkg::st_idle;
            endcase
        end
    end

    // ack trails st_done by one edge and drops on the start edge
    always_ff @(posedge clk) begin
        if (reset) begin
            ack       <= 1'b0;
            timed_out <= 1'b0;
        end else begin
            ack       <= (state == cpu_pkg::st_done) && !restart;
            timed_out <= (state == cpu_pkg::st_done) && !restart && budget_hit;
        end
    end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int INSTR_WIDTH    = 9;  // One instruction word
    localparam int DATA_WIDTH     = 8;  // Register and memory word
    localparam int REG_ADDR_WIDTH = 2;  // Four registers
    localparam int OPCODE_WIDTH   = 3;
    localparam int IMM_WIDTH      = 6;

    // Instruction field positions
    localparam int OPCODE_MSB = 8;
    localparam int OPCODE_LSB = 6;
    localparam int RA_MSB     = 5;
    localparam int RA_LSB     = 4;
    localparam int RB_MSB     = 3;
    localparam int RB_LSB     = 2;
    localparam int LS_BIT     = 1;  // MEM only, 1 selects store
    localparam int IMM_MSB    = 5;
    localparam int IMM_LSB    = 0;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_add  = 3'd0,  // r1 = ra + rb
        op_sub  = 3'd1,  // r1 = ra - rb
        op_and  = 3'd2,  // r1 = ra & rb
        op_xor  = 3'd3,  // r1 = ra ^ rb
        op_halt = 3'd4,  // End of run
        op_li   = 3'd5,  // r1 = zext(imm)
        op_beqz = 3'd6,  // pc += sext(imm) if r1 == 0
        op_mem  = 3'd7   // Load or store through dmem[ra]
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_xor    = 3'd3,
        alu_pass_b = 3'd4  // LI and BEQZ route operand b
    } alu_op_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,  // Out of reset, never started
        st_run  = 2'd1,  // Executing one instruction per cycle
        st_done = 2'd2   // HALT or budget reached
    } run_state_e;

endpackage
